// ==== sources.f ====
+incdir+src
src/egr_sch_types_pkg.sv
src/egr_sch_cfg_pkg.sv
src/egr_sch_cfg_regs.sv
src/egr_sch_req_queue.sv
src/egr_sch_arb_counter.sv
src/egr_sch_arb.sv
src/egr_sch_top.sv
tb/egr_sch_arb_assert.sv
tb/egr_sch_tb.sv

// ==== Makefile ====
# simulate the egress scheduler testbench with Verilator

VERILATOR ?= verilator
TOP       ?= egr_sch_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/egr_sch_tb.sv ====
`timescale 1ns/100ps

`include "egr_sch_params.svh"

module egr_sch_tb;

    import egr_sch_types_pkg::*;
    import egr_sch_cfg_pkg::*;

    localparam int W = `EGR_SCH_WIDTH;
    localparam int NUM_ROWS = 5;
    // cycles a fresh winner is held before the pop pulse
    localparam int HOLD_CYCLES = 2;
    localparam int unsigned RAND_SEED = 32'h52a5_fea3;

    logic clk;
    logic reset;
    logic push;
    req_idx_t push_id;
    cost_t push_cost;
    logic pop;
    logic cfg_we;
    cfg_op_e cfg_op;
    req_idx_t cfg_addr;
    weight_t cfg_data;
    req_vec_t win;
    cost_t win_cost;
    req_vec_t queue_full;

    // test table, one row per test
    string row_name [NUM_ROWS];
    arb_mode_e row_mode [NUM_ROWS];
    logic row_rev [NUM_ROWS];
    int row_weight [NUM_ROWS][W];
    int row_count [NUM_ROWS][W];
    int row_cost_min [NUM_ROWS];
    int row_cost_span [NUM_ROWS];
    // expected first grant, the first queue pushed while all others are empty
    req_vec_t row_first [NUM_ROWS];

    // model FIFOs hold pushed costs in order
    cost_t model_q [W][$];
    string test_name;

    egr_sch_top i_egr_sch_top (
        .clk        (clk),
        .reset      (reset),
        .push       (push),
        .push_id    (push_id),
        .push_cost  (push_cost),
        .pop        (pop),
        .cfg_we     (cfg_we),
        .cfg_op     (cfg_op),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .win        (win),
        .win_cost   (win_cost),
        .queue_full (queue_full)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic abort_with(input string what);
        $display("%s in test %s", what, test_name);
        abort_run();
    endtask

    task automatic check_win(input req_vec_t expected, input req_vec_t actual);
        if (actual !== expected) begin
            $display("Fail %s: expected %b actual %b", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_cost(input cost_t expected, input cost_t actual);
        if (actual !== expected) begin
            $display("Fail %s: cost expected %0d actual %0d", test_name, expected, actual);
            abort_run();
        end
    endtask

    task automatic check_full(input req_vec_t expected, input req_vec_t actual);
        if (actual !== expected) begin
            $display("Fail %s: queue_full expected %b actual %b", test_name, expected, actual);
            abort_run();
        end
    endtask

    // inputs change 1 ns after the rising edge, outputs are read there too
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic set_row(input int r, input string name, input arb_mode_e mode,
                           input logic rev, input int w0, w1, w2, w3,
                           input int n0, n1, n2, n3, input int cmin, cspan,
                           input req_vec_t first);
        row_name[r] = name;
        row_mode[r] = mode;
        row_rev[r] = rev;
        row_weight[r] = '{w0, w1, w2, w3};
        row_count[r] = '{n0, n1, n2, n3};
        row_cost_min[r] = cmin;
        row_cost_span[r] = cspan;
        row_first[r] = first;
    endtask

    task automatic fill_table();
        // name, mode, rev, weights 0..3, pushes 0..3, cost base and span, first win
        // queue 2 of the first row is filled to its depth
        set_row(0, "static_fwd", ARB_STATIC, 1'b0, 0, 0, 0, 0, 3, 2, 8, 1, 0, 64, 4'b0001);
        set_row(1, "static_rev", ARB_STATIC, 1'b1, 0, 0, 0, 0, 2, 3, 1, 4, 0, 64, 4'b1000);
        set_row(2, "round_robin", ARB_RR, 1'b0, 0, 0, 0, 0, 4, 3, 5, 2, 0, 64, 4'b0001);
        set_row(3, "weighted_rr", ARB_WRR, 1'b0, 2, 3, 1, 4, 6, 6, 6, 6, 0, 64, 4'b0001);
        // costs 5..8 against weights of 8 or more, one quantum covers any head
        set_row(4, "deficit_rr", ARB_DRR, 1'b0, 8, 12, 10, 15, 6, 6, 6, 6, 5, 4, 4'b0001);
    endtask

    // static: lowest (or highest) pending index; rr: next pending above prev_idx
    function automatic req_vec_t expected_winner(input int r, input int prev_idx);
        req_vec_t v;
        int j;
        v = '0;
        // walk from least to most preferred, the last hit wins
        for (int k = W; k >= 1; k--) begin
            if (row_mode[r] == ARB_RR) begin
                j = (prev_idx + k) % W;
            end else begin
                j = row_rev[r] ? W - k : k - 1;
            end
            if (model_q[j].size() > 0) v = req_vec_t'(1) << j;
        end
        return v;
    endfunction

    // a queue is full once the model holds a whole FIFO depth
    function automatic req_vec_t expected_full();
        req_vec_t v;
        v = '0;
        for (int i = 0; i < W; i++) begin
            if (model_q[i].size() >= `EGR_SCH_QUEUE_DEPTH) v[i] = 1'b1;
        end
        return v;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // per-row phases
    ////////////////////////////////////////////////////////////////////////////

    task automatic write_cfg(input cfg_op_e op, input req_idx_t addr, input weight_t data);
        cfg_we = 1'b1;
        cfg_op = op;
        cfg_addr = addr;
        cfg_data = data;
        next_cycle();
        cfg_we = 1'b0;
    endtask

    task automatic configure_row(input int r);
        write_cfg(CFG_OP_MODE, '0, weight_t'(row_mode[r]));
        write_cfg(CFG_OP_REV, '0, weight_t'(row_rev[r]));
        for (int i = 0; i < W; i++) begin
            write_cfg(CFG_OP_WEIGHT, req_idx_t'(i), weight_t'(row_weight[r][i]));
        end
        // weight derivatives in the counters lag by two cycles
        repeat (4) next_cycle();
    endtask

    // queues filled in search order, pop held low throughout
    task automatic push_row(input int r);
        int q;
        cost_t c;
        for (int k = 0; k < W; k++) begin
            q = row_rev[r] ? W - 1 - k : k;
            for (int n = 0; n < row_count[r][q]; n++) begin
                if (model_q[q].size() >= `EGR_SCH_QUEUE_DEPTH) begin
                    abort_with("push attempted into a full queue");
                end
                // no pop yet, so the fill levels follow the model exactly
                check_full(expected_full(), queue_full);
                c = cost_t'(row_cost_min[r] + int'($urandom % row_cost_span[r]));
                model_q[q].push_back(c);
                push = 1'b1;
                push_id = req_idx_t'(q);
                push_cost = c;
                next_cycle();
            end
        end
        push = 1'b0;
        check_full(expected_full(), queue_full);
    endtask

    task automatic drain_row(input int r);
        req_vec_t held_win;
        req_vec_t served;
        req_vec_t active;
        cost_t held_cost;
        logic weighted;
        int left;
        int idx;
        int prev_idx;
        left = 0;
        idx = 0;
        prev_idx = 0;
        served = '0;
        active = '0;
        weighted = (row_mode[r] == ARB_WRR) || (row_mode[r] == ARB_DRR);
        for (int i = 0; i < W; i++) begin
            left += row_count[r][i];
            if (row_count[r][i] > 0) active[i] = 1'b1;
        end
        while (left > 0) begin
            if (win == '0) begin
                // empty slot after a repeat pick, or still arbitrating
                next_cycle();
            end else begin
                if (!$onehot(win)) abort_with("win has more than one bit set");
                for (int i = 0; i < W; i++) begin
                    if (win[i]) idx = i;
                end
                if (model_q[idx].size() == 0) abort_with("requester granted with no descriptor");
                // ordering known for the first grant and for static and rr modes
                if (served == '0) begin
                    check_win(row_first[r], win);
                end else if (!weighted) begin
                    check_win(expected_winner(r, prev_idx), win);
                end
                check_cost(model_q[idx][0], win_cost);
                held_win = win;
                held_cost = win_cost;
                // back-pressure, nothing moves while pop is low
                repeat (HOLD_CYCLES) begin
                    next_cycle();
                    check_win(held_win, win);
                    check_cost(held_cost, win_cost);
                end
                void'(model_q[idx].pop_front());
                served[idx] = 1'b1;
                left--;
                // no queue takes its last grant before every loaded queue was served
                if (weighted && model_q[idx].size() == 0) check_win(active, served);
                pop = 1'b1;
                next_cycle();
                pop = 1'b0;
                prev_idx = idx;
            end
        end
        repeat (3) next_cycle();
        check_win('0, win);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int unsigned seed_draw;
        reset = 1'b1;
        push = 1'b0;
        push_id = '0;
        push_cost = '0;
        pop = 1'b0;
        cfg_we = 1'b0;
        cfg_op = CFG_OP_MODE;
        cfg_addr = '0;
        cfg_data = '0;
        test_name = "reset";
        seed_draw = $urandom(RAND_SEED);
        fill_table();
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        check_win('0, win);
        for (int r = 0; r < NUM_ROWS; r++) begin
            test_name = row_name[r];
            configure_row(r);
            push_row(r);
            drain_row(r);
        end
        $display("** PASS **");
        $finish;
    end

    // limit is rows times the largest row's pushes times 20 cycles
    initial begin
        int most;
        int pushes;
        int limit;
        @(negedge reset);
        most = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            pushes = 0;
            for (int i = 0; i < W; i++) begin
                pushes += row_count[r][i];
            end
            if (pushes > most) most = pushes;
        end
        limit = NUM_ROWS * most * 20;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the scheduler stopped granting", limit);
        abort_run();
    end

endmodule

// ==== tb/egr_sch_arb_assert.sv ====
`timescale 1ns/100ps

module egr_sch_arb_assert (
    input  logic                          clk,
    input  logic                          reset,
    input  egr_sch_types_pkg::req_vec_t   pop,
    input  egr_sch_types_pkg::req_vec_t   win,
    input  egr_sch_types_pkg::cost_t      win_cost
);

    // at most one requester holds the output
    win_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(win))
        else $error("win has more than one bit set");

    // a held winner and its cost stay put until popped
    win_hold: assert property (@(posedge clk) disable iff (reset)
        (win != '0 && pop == '0) |=> ($stable(win) && $stable(win_cost)))
        else $error("win or win_cost changed while pop was low");

    // reset clears the winner
    win_reset: assert property (@(posedge clk) reset |=> (win == '0))
        else $error("win not zero in the cycle after reset");

endmodule

// attach to every arbiter instance
bind egr_sch_arb egr_sch_arb_assert i_arb_assert (
    .clk      (clk),
    .reset    (reset),
    .pop      (pop),
    .win      (win),
    .win_cost (win_cost)
);

// ==== src/egr_sch_top.sv ====
`timescale 1ns/100ps

`include "egr_sch_params.svh"

module egr_sch_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           push,
    input  egr_sch_cfg_pkg::req_idx_t      push_id,
    input  egr_sch_types_pkg::cost_t       push_cost,
    input  logic                           pop,
    input  logic                           cfg_we,
    input  egr_sch_cfg_pkg::cfg_op_e       cfg_op,
    input  egr_sch_cfg_pkg::req_idx_t      cfg_addr,
    input  egr_sch_types_pkg::weight_t     cfg_data,
    output egr_sch_types_pkg::req_vec_t    win,
    output egr_sch_types_pkg::cost_t       win_cost,
    output egr_sch_types_pkg::req_vec_t    queue_full
);

    import egr_sch_types_pkg::*;

    req_vec_t push_vec;
    req_vec_t pop_vec;
    req_vec_t arb;
    cost_vec_t arb_cost;
    weight_vec_t cfg_weight;
    logic cfg_rr;
    logic cfg_rev;
    logic cfg_cost;

    // push steered by id, pop goes to the current winner
    assign push_vec = req_vec_t'(push) << push_id;
    assign pop_vec = win & {`EGR_SCH_WIDTH{pop}};

    egr_sch_cfg_regs i_cfg_regs (
        .clk        (clk),
        .reset      (reset),
        .cfg_we     (cfg_we),
        .cfg_op     (cfg_op),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .cfg_rr     (cfg_rr),
        .cfg_rev    (cfg_rev),
        .cfg_cost   (cfg_cost),
        .cfg_weight (cfg_weight)
    );

    for (genvar i = 0; i < `EGR_SCH_WIDTH; i++) begin : g_queue
        egr_sch_req_queue i_queue (
            .clk       (clk),
            .reset     (reset),
            .push      (push_vec[i]),
            .push_cost (push_cost),
            .pop       (pop_vec[i]),
            .arb       (arb[i]),
            .arb_cost  (arb_cost[i]),
            .full      (queue_full[i])
        );
    end

    egr_sch_arb i_arb (
        .clk        (clk),
        .reset      (reset),
        .arb        (arb),
        .arb_cost   (arb_cost),
        .pop        (pop_vec),
        .cfg_weight (cfg_weight),
        .cfg_rr     (cfg_rr),
        .cfg_rev    (cfg_rev),
        .cfg_cost   (cfg_cost),
        .win        (win),
        .win_cost   (win_cost)
    );

endmodule

// ==== src/egr_sch_arb.sv ====
`timescale 1ns/100ps

`include "egr_sch_params.svh"

module egr_sch_arb (
    input  logic                             clk,
    input  logic                             reset,
    input  egr_sch_types_pkg::req_vec_t      arb,
    input  egr_sch_types_pkg::cost_vec_t     arb_cost,
    input  egr_sch_types_pkg::req_vec_t      pop,
    input  egr_sch_types_pkg::weight_vec_t   cfg_weight,
    input  logic                             cfg_rr,
    input  logic                             cfg_rev,
    input  logic                             cfg_cost,
    output egr_sch_types_pkg::req_vec_t      win,
    output egr_sch_types_pkg::cost_t         win_cost
);

    import egr_sch_types_pkg::*;

    localparam int W = `EGR_SCH_WIDTH;

    req_vec_t ready;
    req_vec_t quanta_ready;
    req_vec_t min_quanta;
    req_vec_t consume;
    cost_vec_t cost;
    cost_vec_t quanta_needed;
    logic increment;
    cost_t increment_quanta;

    req_vec_t ready_s;
    req_vec_t find_short;
    req_vec_t rr_ptr;
    logic [2*W-1:0] ready_pos;
    logic [2*W-1:0] ready_mask;
    logic [2*W-1:0] ready_find;

    req_vec_t pick;
    req_vec_t pick_s;
    cost_t pick_cost;
    logic load;
    logic bubble;
    logic grant;

    function automatic req_vec_t flip(input req_vec_t v);
        req_vec_t r;
        for (int i = 0; i < W; i++) begin
            r[i] = v[W-1-i];
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // priority and round-robin search
    ////////////////////////////////////////////////////////////////////////////

    // search runs from bit 0 upward, reverse mode mirrors the vector
    assign ready_s = cfg_rev ? flip(ready) : ready;

    // lower half covers indices past the last winner, upper half wraps
    assign ready_pos = {rr_ptr, ~rr_ptr};
    assign ready_mask = {ready_s, ready_s} & ready_pos;
    assign ready_find = ready_mask & ~(ready_mask - 1'b1);
    assign find_short = ready_find[W-1:0] | ready_find[2*W-1:W];

    // pointer all ones means plain priority from bit 0
    always_ff @(posedge clk) begin
        if (reset || !cfg_rr) begin
            rr_ptr <= '1;
        end else if (grant) begin
            rr_ptr <= pick_s | (pick_s - 1'b1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // credit counters and selection
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < W; i++) begin : g_cnt
        egr_sch_arb_counter i_cnt (
            .clk              (clk),
            .reset            (reset),
            .consume          (consume[i]),
            .arb              (arb[i]),
            .arb_cost         (arb_cost[i]),
            .increment        (increment),
            .increment_quanta (increment_quanta),
            .weight           (cfg_weight[i]),
            .cfg_cost         (cfg_cost),
            .ready            (ready[i]),
            .quanta_ready     (quanta_ready[i]),
            .cost             (cost[i]),
            .quanta_needed    (quanta_needed[i])
        );
    end

    // lowest-index waiter sizes the global increment
    assign min_quanta = quanta_ready & ~(quanta_ready - 1'b1);

    always_comb begin
        if (|ready) begin
            pick = cfg_rev ? flip(find_short) : find_short;
        end else if (|quanta_ready) begin
            pick = min_quanta;
        end else begin
            pick = arb & ~(arb - 1'b1);
        end
    end

    // pick in search order, for the pointer
    assign pick_s = cfg_rev ? flip(pick) : pick;

    // the popped winner still shows its old head this cycle, so a repeat
    // pick of it becomes an empty slot and is retried next cycle
    assign load = |pop || ~|win;
    assign bubble = |(pick & pop);
    assign grant = load && !bubble && |pick;

    assign consume = pick & {W{grant}};
    assign increment = grant && ~|ready && |quanta_ready;

    always_comb begin
        increment_quanta = '0;
        pick_cost = '0;
        for (int i = 0; i < W; i++) begin
            if (min_quanta[i]) increment_quanta |= quanta_needed[i];
            if (pick[i]) pick_cost |= cost[i];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered win
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            win <= '0;
        end else if (load) begin
            win <= grant ? pick : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (grant) win_cost <= pick_cost;
    end

endmodule

// ==== src/egr_sch_arb_counter.sv ====
`timescale 1ns/100ps

module egr_sch_arb_counter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         consume,
    input  logic                         arb,
    input  egr_sch_types_pkg::cost_t     arb_cost,
    input  logic                         increment,
    input  egr_sch_types_pkg::cost_t     increment_quanta,
    input  egr_sch_types_pkg::weight_t   weight,
    input  logic                         cfg_cost,
    output logic                         ready,
    output logic                         quanta_ready,
    output egr_sch_types_pkg::cost_t     cost,
    output egr_sch_types_pkg::cost_t     quanta_needed
);

    import egr_sch_types_pkg::*;

    localparam int SHIFT_W = $clog2(WEIGHT_W + 1);

    logic skip_count;
    weight_t weight_dec;
    logic [SHIFT_W-1:0] dec_bits;
    logic weight_pow2;
    logic [SHIFT_W-1:0] shift_d;
    logic [SHIFT_W-1:0] weight_shift;
    weight_t weight_cap;

    credit_t credits;
    credit_t charge;
    credit_t deficit;
    credit_t rounded;
    logic [COST_W+WEIGHT_W-1:0] inc_credit;
    logic covered;

    ////////////////////////////////////////////////////////////////////////////
    // weight derivatives, two register stages
    ////////////////////////////////////////////////////////////////////////////

    // stage one: zero weight disables counting
    always_ff @(posedge clk) begin
        skip_count <= (weight == '0);
        weight_dec <= weight - 1'b1;
    end

    // bit length of weight - 1
    always_comb begin
        dec_bits = '0;
        for (int i = 0; i < WEIGHT_W; i++) begin
            if (weight_dec[i]) dec_bits = SHIFT_W'(i + 1);
        end
    end

    // floor(log2(weight)), so the quanta estimate never falls short
    assign weight_pow2 = (((weight_dec + 1'b1) & weight_dec) == '0);
    assign shift_d = weight_pow2 ? dec_bits : dec_bits - 1'b1;

    // stage two: divide shift and its round-up cap
    always_ff @(posedge clk) begin
        weight_shift <= shift_d;
        weight_cap <= weight_t'((1 << shift_d) - 1);
    end

    ////////////////////////////////////////////////////////////////////////////
    // credit balance
    ////////////////////////////////////////////////////////////////////////////

    // head cost as seen by this requester
    assign cost = arb_cost;

    // WRR charges one credit per grant, DRR the head cost
    assign charge = cfg_cost ? credit_t'(arb_cost) : credit_t'(1);
    assign covered = skip_count || (credits >= charge);

    assign ready = arb && covered;
    assign quanta_ready = arb && !covered;

    // quanta = ceil(deficit / 2^shift)
    assign deficit = charge - credits;
    assign rounded = (deficit + credit_t'(weight_cap)) >> weight_shift;
    assign quanta_needed = quanta_ready ? cost_t'(rounded) : '0;

    assign inc_credit = weight * increment_quanta;

    // idle requesters lose their balance
    always_ff @(posedge clk) begin
        if (reset || !arb || skip_count) begin
            credits <= '0;
        end else begin
            case ({consume, increment})
                2'b11: credits <= credits + credit_t'(inc_credit) - charge;
                2'b10: credits <= credits - charge;
                2'b01: credits <= credits + credit_t'(inc_credit);
                default: credits <= credits;
            endcase
        end
    end

endmodule

// ==== src/egr_sch_req_queue.sv ====
`timescale 1ns/100ps

`include "egr_sch_params.svh"

module egr_sch_req_queue (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  egr_sch_types_pkg::cost_t   push_cost,
    input  logic                       pop,
    output logic                       arb,
    output egr_sch_types_pkg::cost_t   arb_cost,
    output logic                       full
);

    import egr_sch_types_pkg::*;

    localparam int DEPTH = `EGR_SCH_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // descriptor storage, cost only
    cost_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;
    logic do_push;
    logic do_pop;

    // push into a full queue is dropped, pop of an empty one ignored
    assign do_push = push && !full;
    assign do_pop = pop && arb;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_cost;
        end
    end

    // pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // request stays up until the last entry is popped
    assign arb = (count != '0);
    assign full = (count == (PTR_W+1)'(DEPTH));
    assign arb_cost = mem[rd_ptr];

endmodule

// ==== src/egr_sch_cfg_regs.sv ====
`timescale 1ns/100ps

module egr_sch_cfg_regs (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             cfg_we,
    input  egr_sch_cfg_pkg::cfg_op_e         cfg_op,
    input  egr_sch_cfg_pkg::req_idx_t        cfg_addr,
    input  egr_sch_types_pkg::weight_t       cfg_data,
    output logic                             cfg_rr,
    output logic                             cfg_rev,
    output logic                             cfg_cost,
    output egr_sch_types_pkg::weight_vec_t   cfg_weight
);

    import egr_sch_cfg_pkg::*;

    // stored mode, decoded below into the arbiter mode bits
    arb_mode_e mode_q;

    ////////////////////////////////////////////////////////////////////////////
    // register writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q <= ARB_STATIC;
            cfg_rev <= 1'b0;
            cfg_weight <= '0;
        end else if (cfg_we) begin
            case (cfg_op)
                // mode sits in the low data bits
                CFG_OP_MODE: begin
                    mode_q <= arb_mode_e'(cfg_data[$bits(arb_mode_e)-1:0]);
                end
                // search direction, bit 0 only
                CFG_OP_REV: begin
                    cfg_rev <= cfg_data[0];
                end
                // one weight per requester, addressed by index
                CFG_OP_WEIGHT: begin
                    cfg_weight[cfg_addr] <= cfg_data;
                end
                default: begin
                    mode_q <= mode_q;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode decode
    ////////////////////////////////////////////////////////////////////////////

    // every mode but static walks a round-robin pointer
    assign cfg_rr = (mode_q != ARB_STATIC);

    // only DRR charges the head cost, WRR charges one credit per grant
    assign cfg_cost = (mode_q == ARB_DRR);

endmodule

// ==== src/egr_sch_cfg_pkg.sv ====
`include "egr_sch_params.svh"

package egr_sch_cfg_pkg;

    // arbitration mode as stored by the config registers
    typedef enum logic [1:0] {
        ARB_STATIC = 2'd0,
        ARB_RR     = 2'd1,
        ARB_WRR    = 2'd2,
        ARB_DRR    = 2'd3
    } arb_mode_e;

    // config write opcode
    typedef enum logic [1:0] {
        CFG_OP_MODE   = 2'd0,
        CFG_OP_REV    = 2'd1,
        CFG_OP_WEIGHT = 2'd2
    } cfg_op_e;

    // requester index, used as weight table address and push id
    typedef logic [$clog2(`EGR_SCH_WIDTH)-1:0] req_idx_t;

endpackage

// ==== src/egr_sch_types_pkg.sv ====
`include "egr_sch_params.svh"

package egr_sch_types_pkg;

    // field widths derived from the bounds
    localparam int COST_W = $clog2(`EGR_SCH_MAX_COST);
    localparam int WEIGHT_W = $clog2(`EGR_SCH_TOTAL_QUANTA);

    // one bit per requester
    typedef logic [`EGR_SCH_WIDTH-1:0] req_vec_t;

    // descriptor cost and credits granted per quantum
    typedef logic [COST_W-1:0] cost_t;
    typedef logic [WEIGHT_W-1:0] weight_t;

    // signed credit balance, room for cost times weight plus sign
    typedef logic signed [COST_W+WEIGHT_W:0] credit_t;

    // per-requester arrays
    typedef cost_t [`EGR_SCH_WIDTH-1:0] cost_vec_t;
    typedef weight_t [`EGR_SCH_WIDTH-1:0] weight_vec_t;

endpackage

// ==== src/egr_sch_params.svh ====
`ifndef EGR_SCH_PARAMS_SVH
`define EGR_SCH_PARAMS_SVH

// number of requester queues feeding the scheduler
`define EGR_SCH_WIDTH 4

// upper bound on a per-requester weight
`define EGR_SCH_TOTAL_QUANTA 16

// upper bound on a descriptor cost
`define EGR_SCH_MAX_COST 64

// descriptor entries per requester FIFO
`define EGR_SCH_QUEUE_DEPTH 8

`endif
